// ==== rtl/cuPkg.sv ====
////////////////////////////////////////
// Control unit package
// Microinstruction, condition and instruction types
////////////////////////////////////////
package cuPkg;

	// Microprogram address width, 32 states
	localparam int stateW = 5;

	typedef logic [stateW-1:0] state_t;

	// Condition select codes in the sequencing field
	localparam logic [1:0] condMoc = 2'd0;
	localparam logic [1:0] condBranch = 2'd1;
	localparam logic [1:0] condZero = 2'd2;
	localparam logic [1:0] condAlways = 2'd3;

	// Instruction classes by op field
	localparam logic [1:0] opBranch = 2'd0;
	localparam logic [1:0] opCall = 2'd1;
	localparam logic [1:0] opArith = 2'd2;
	localparam logic [1:0] opMem = 2'd3;

	// Datapath control word
	typedef struct packed {
		// Register loads and memory strobes
		logic mov;
		logic rw;
		logic marLd;
		logic mdrLd;
		logic irLd;
		logic pcLd;
		logic npcLd;
		logic rfLd;
		logic frLd;
		// Carry in and mux selects
		logic cin;
		logic ma;
		logic mc;
		logic me;
		logic mf;
		logic mg;
		// Memory side strobes, raised in fetch only
		logic mh;
		logic mi;
		logic [1:0] mb;
		logic [1:0] md;
		logic [5:0] aluOp;
	} dpCtrl_t;

	// Next-address modes, codes 0, 1 and 6 fall back to state 0
	typedef enum logic [2:0] {
		selJump = 3'd2,
		selInc = 3'd3,
		selDispatch = 3'd4,
		selCondInc = 3'd5,
		selCondDispatch = 3'd7
	} nextSel_t;

	typedef struct packed {
		nextSel_t nextSel;
		logic inv;
		logic [1:0] condSel;
		state_t target;
	} seqCtrl_t;

	typedef struct packed {
		dpCtrl_t dp;
		seqCtrl_t seq;
	} microInstr_t;

	// Reset word, holds the sequencer in state 0
	localparam microInstr_t idleMicroInstr = '{
		dp: '0,
		seq: '{nextSel: selJump, inv: 1'b0, condSel: condMoc, target: '0}
	};

	typedef struct packed {
		logic moc;
		logic branchCond;
		logic zeroFlag;
	} seqCond_t;

	typedef struct packed {
		logic [1:0] op;
		logic [5:0] op3;
		logic immBit;
		logic setCc;
	} instrFields_t;

endpackage

// ==== rtl/dispatchEncoder.sv ====
////////////////////////////////////////
// Dispatch encoder
// Instruction class to first microprogram state
////////////////////////////////////////
module dispatchEncoder (
	input cuPkg::instrFields_t instr,
	output cuPkg::state_t dispatchState
);

	always_comb
	begin
		case (instr.op)
			cuPkg::opBranch:
				dispatchState = 5'd12;
			cuPkg::opCall:
				dispatchState = 5'd10;
			cuPkg::opArith:
			begin
				// Register or immediate operand, with or without flag update
				if (instr.immBit)
					dispatchState = instr.setCc ? 5'd8 : 5'd7;
				else
					dispatchState = instr.setCc ? 5'd6 : 5'd5;
			end
			cuPkg::opMem:
			begin
				// op3 bit 2 splits stores from loads
				if (instr.op3[2])
					dispatchState = 5'd20;
				else
					dispatchState = 5'd16;
			end
			default:
				dispatchState = '0;
		endcase
	end

endmodule

// ==== rtl/microSequencer.sv ====
////////////////////////////////////////
// Microsequencer
// State register and next-address select
////////////////////////////////////////
module microSequencer (
	input logic clk,
	input logic rstN,
	input cuPkg::seqCtrl_t seq,
	input cuPkg::seqCond_t cond,
	input cuPkg::state_t dispatchState,
	output cuPkg::state_t nextState,
	output cuPkg::state_t state
);

	logic condSelected;
	logic condTrue;
	cuPkg::state_t incState;

	always_comb
	begin
		case (seq.condSel)
			cuPkg::condMoc:
				condSelected = cond.moc;
			cuPkg::condBranch:
				condSelected = cond.branchCond;
			cuPkg::condZero:
				condSelected = cond.zeroFlag;
			default:
				condSelected = 1'b1;
		endcase
	end

	// Invert bit lets a state wait while moc is still low
	assign condTrue = condSelected ^ seq.inv;
	assign incState = state + cuPkg::state_t'(1);

	always_comb
	begin
		case (seq.nextSel)
			cuPkg::selInc:
				nextState = incState;
			cuPkg::selJump:
				nextState = seq.target;
			cuPkg::selDispatch:
				nextState = dispatchState;
			cuPkg::selCondInc:
				nextState = condTrue ? seq.target : incState;
			cuPkg::selCondDispatch:
				nextState = condTrue ? seq.target : dispatchState;
			default:
				nextState = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			state <= '0;
		else
			state <= nextState;
	end

endmodule

// ==== rtl/microstore.sv ====
////////////////////////////////////////
// Microstore
// 32-row microprogram with registered output
////////////////////////////////////////
module microstore (
	input logic clk,
	input logic rstN,
	input cuPkg::state_t nextState,
	output cuPkg::dpCtrl_t ctrl,
	output cuPkg::seqCtrl_t seq
);

	cuPkg::microInstr_t romRow;
	cuPkg::microInstr_t current;

	// Packs one row, loads and selects in struct order
	function automatic cuPkg::microInstr_t uRow(
		input logic [8:0] loads,
		input logic [7:0] sels,
		input logic [1:0] mb,
		input logic [1:0] md,
		input logic [5:0] aluOp,
		input cuPkg::nextSel_t sel,
		input logic inv,
		input logic [1:0] condSel,
		input cuPkg::state_t target
	);
		return {loads, sels, mb, md, aluOp, sel, inv, condSel, target};
	endfunction

	always_comb
	begin
		case (nextState)
			// Fetch
			5'd0: romRow = uRow(9'b000001101, 8'b00000000, 2'b00, 2'b10, 6'h02,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd1: romRow = uRow(9'b011001000, 8'b00010010, 2'b11, 2'b01, 6'h3a,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd1);
			5'd2: romRow = uRow(9'b110000000, 8'b00010000, 2'b11, 2'b01, 6'h3a,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd3: romRow = uRow(9'b110010000, 8'b00010001, 2'b11, 2'b01, 6'h3a,
				cuPkg::selCondInc, 1'b1, cuPkg::condMoc, 5'd3);
			5'd4: romRow = uRow(9'b010000100, 8'b00000000, 2'b11, 2'b01, 6'h3a,
				cuPkg::selDispatch, 1'b0, cuPkg::condBranch, 5'd1);
			// ALU, register and immediate forms
			5'd5: romRow = uRow(9'b010000010, 8'b00100000, 2'b00, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			5'd6: romRow = uRow(9'b000000011, 8'b00100000, 2'b00, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			5'd7: romRow = uRow(9'b000000010, 8'b00100000, 2'b01, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			5'd8: romRow = uRow(9'b000000011, 8'b00100000, 2'b01, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			5'd9: romRow = uRow(9'b000000010, 8'b00000000, 2'b00, 2'b11, 6'h25,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			// Call
			5'd10: romRow = uRow(9'b000001010, 8'b00010100, 2'b11, 2'b00, 6'h02,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd11: romRow = uRow(9'b000000100, 8'b00000000, 2'b11, 2'b00, 6'h38,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			// Branch, taken path on zero flag
			5'd12: romRow = uRow(9'b000000010, 8'b00000000, 2'b11, 2'b00, 6'h02,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd13: romRow = uRow(9'b000001000, 8'b00010000, 2'b00, 2'b00, 6'h00,
				cuPkg::selCondInc, 1'b0, cuPkg::condZero, 5'd15);
			5'd14: romRow = uRow(9'b000000100, 8'b00100000, 2'b00, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			5'd15: romRow = uRow(9'b000000100, 8'b00100000, 2'b01, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			// Load, 17 and 18 shared with store
			5'd16: romRow = uRow(9'b011000000, 8'b00000000, 2'b00, 2'b00, 6'h00,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd17: romRow = uRow(9'b110000000, 8'b00000000, 2'b10, 2'b00, 6'h00,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd17);
			5'd18: romRow = uRow(9'b110100000, 8'b00000000, 2'b10, 2'b00, 6'h00,
				cuPkg::selCondInc, 1'b1, cuPkg::condMoc, 5'd18);
			5'd19: romRow = uRow(9'b010000010, 8'b00000000, 2'b10, 2'b00, 6'h0a,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			// Store
			5'd20: romRow = uRow(9'b011000000, 8'b00000000, 2'b01, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd17);
			5'd21: romRow = uRow(9'b001000000, 8'b01000000, 2'b00, 2'b00, 6'h00,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd22: romRow = uRow(9'b000100000, 8'b01000000, 2'b00, 2'b00, 6'h00,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd23: romRow = uRow(9'b000000000, 8'b01000000, 2'b00, 2'b00, 6'h00,
				cuPkg::selCondDispatch, 1'b1, cuPkg::condMoc, 5'd23);
			5'd24: romRow = uRow(9'b001000000, 8'b01001000, 2'b00, 2'b00, 6'h00,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd22);
			// Always-true inverted, so 25 just falls through
			5'd25: romRow = uRow(9'b000000100, 8'b00000000, 2'b01, 2'b00, 6'h3f,
				cuPkg::selCondInc, 1'b1, cuPkg::condAlways, 5'd27);
			5'd26: romRow = uRow(9'b000000000, 8'b00001000, 2'b01, 2'b00, 6'h3f,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd17);
			5'd27: romRow = uRow(9'b000000000, 8'b00000000, 2'b00, 2'b00, 6'h00,
				cuPkg::selCondInc, 1'b1, cuPkg::condMoc, 5'd30);
			5'd28: romRow = uRow(9'b000001000, 8'b00000000, 2'b11, 2'b01, 6'h3e,
				cuPkg::selInc, 1'b0, cuPkg::condMoc, 5'd0);
			5'd29: romRow = uRow(9'b000000100, 8'b00000000, 2'b11, 2'b01, 6'h3c,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			5'd30: romRow = uRow(9'b000001100, 8'b00010000, 2'b11, 2'b01, 6'h3e,
				cuPkg::selJump, 1'b0, cuPkg::condMoc, 5'd1);
			// State 31 undefined, zero row sends the sequencer to 0
			default: romRow = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			current <= cuPkg::idleMicroInstr;
		else
			current <= romRow;
	end

	assign ctrl = current.dp;
	assign seq = current.seq;

endmodule

// ==== rtl/controlUnit.sv ====
////////////////////////////////////////
// Control unit top
// Encoder, sequencer and microstore
////////////////////////////////////////
module controlUnit (
	input logic clk,
	input logic rstN,
	input cuPkg::instrFields_t instr,
	input cuPkg::seqCond_t cond,
	output cuPkg::dpCtrl_t ctrl,
	output cuPkg::state_t state
);

	cuPkg::state_t dispatchState;
	cuPkg::state_t nextState;
	cuPkg::seqCtrl_t seq;

	dispatchEncoder i_dispatchEncoder (
		.instr(instr),
		.dispatchState(dispatchState)
	);

	microSequencer i_microSequencer (
		.clk(clk),
		.rstN(rstN),
		.seq(seq),
		.cond(cond),
		.dispatchState(dispatchState),
		.nextState(nextState),
		.state(state)
	);

	// Row for nextState lands with the state it belongs to
	microstore i_microstore (
		.clk(clk),
		.rstN(rstN),
		.nextState(nextState),
		.ctrl(ctrl),
		.seq(seq)
	);

endmodule

// ==== test/controlUnit_assert.sv ====
////////////////////////////////////////
// Control unit checker
// Sequencing and control word assertions
////////////////////////////////////////
module controlUnitAssert (
	input logic clk,
	input logic rstN,
	input cuPkg::instrFields_t instr,
	input cuPkg::seqCond_t cond,
	input cuPkg::dpCtrl_t ctrl,
	input cuPkg::state_t state
);

	int errorCount = 0;
	cuPkg::state_t expDispatch;
	cuPkg::state_t prevState;
	cuPkg::state_t prevDispatch;
	logic prevMoc;
	logic prevZero;

	// First state of each instruction class
	always_comb
	begin
		case (instr.op)
			2'd0: expDispatch = 5'd12;
			2'd1: expDispatch = 5'd10;
			// 5 to 8 by immediate and flag update
			2'd2: expDispatch = 5'd5 + {3'd0, instr.immBit, instr.setCc};
			default: expDispatch = instr.op3[2] ? 5'd20 : 5'd16;
		endcase
	end

	// Values from the cycle that left the state
	always_ff @(posedge clk)
	begin
		prevState <= state;
		prevDispatch <= expDispatch;
		prevMoc <= cond.moc;
		prevZero <= cond.zeroFlag;
	end

	// Wait states hold (27 parks at 30), exits step by one
	function automatic cuPkg::state_t memNext(input cuPkg::state_t s, input logic moc);
		return moc ? s + 5'd1 : ((s == 5'd27) ? 5'd30 : s);
	endfunction

	function automatic cuPkg::state_t jumpTarget(input cuPkg::state_t s, input logic zero);
		case (s)
			5'd13: return zero ? 5'd15 : 5'd14;
			5'd20, 5'd26: return 5'd17;
			5'd24: return 5'd22;
			default: return 5'd1;
		endcase
	endfunction

	resetIdle: assert property (@(posedge clk) !rstN |=> (ctrl == '0 && state == '0))
	else
	begin
		errorCount++;
		$error("Mismatch after reset: ctrl %h, state %h", $sampled(ctrl), $sampled(state));
	end

	resetRow0: assert property (@(posedge clk) disable iff (!rstN)
		$rose(rstN) |=> (state == '0 && ctrl.pcLd && ctrl.npcLd && ctrl.frLd))
	else
	begin
		errorCount++;
		$error("Mismatch row 0: state %h, ctrl %h", $sampled(state), $sampled(ctrl));
	end

	fetchStep: assert property (@(posedge clk) disable iff (!rstN)
		(state == 5'd1 || state == 5'd2 || (state == 5'd0 && !$rose(rstN)))
		|=> state == prevState + 5'd1)
	else
	begin
		errorCount++;
		$error("Mismatch state: got %h, expected %h", $sampled(state),
			$sampled(prevState) + 5'd1);
	end

	// MAR load in state 1, IR load in state 3
	fetchStrobes: assert property (@(posedge clk) disable iff (!rstN)
		(state != 5'd1 || (ctrl.marLd && ctrl.mh)) && (state != 5'd3 || (ctrl.irLd && ctrl.mi)))
	else
	begin
		errorCount++;
		$error("Mismatch fetch strobes in state %h: ctrl %h", $sampled(state), $sampled(ctrl));
	end

	memWait: assert property (@(posedge clk) disable iff (!rstN)
		(state inside {5'd3, 5'd18, 5'd27} || (state == 5'd23 && !cond.moc))
		|=> state == memNext(prevState, prevMoc))
	else
	begin
		errorCount++;
		$error("Mismatch state: got %h, expected %h", $sampled(state),
			memNext($sampled(prevState), $sampled(prevMoc)));
	end

	dispatchNext: assert property (@(posedge clk) disable iff (!rstN)
		(state == 5'd4 || (state == 5'd23 && cond.moc)) |=> state == prevDispatch)
	else
	begin
		errorCount++;
		$error("Mismatch state: got %h, expected %h", $sampled(state), $sampled(prevDispatch));
	end

	jumpNext: assert property (@(posedge clk) disable iff (!rstN)
		state inside {[5'd5:5'd9], 5'd11, [5'd13:5'd15], 5'd19, 5'd20, 5'd24, 5'd26, 5'd29, 5'd30}
		|=> state == jumpTarget(prevState, prevZero))
	else
	begin
		errorCount++;
		$error("Mismatch state: got %h, expected %h", $sampled(state),
			jumpTarget($sampled(prevState), $sampled(prevZero)));
	end

endmodule

bind controlUnit controlUnitAssert i_controlUnitAssert (.clk(clk), .rstN(rstN),
	.instr(instr), .cond(cond), .ctrl(ctrl), .state(state));

// ==== test/controlUnitTb.sv ====
////////////////////////////////////////
// Control unit testbench
// Random instructions with memory delays
////////////////////////////////////////
module controlUnitTb;

	localparam int testCount = 48;
	localparam int cyclesPerTest = 24;
	localparam int resetCycles = 4;
	localparam int cycleLimit = testCount * cyclesPerTest + resetCycles;

	logic clk;
	logic rstN;
	cuPkg::instrFields_t instr;
	cuPkg::seqCond_t cond;
	cuPkg::dpCtrl_t ctrl;
	cuPkg::state_t state;

	logic [31:0] seed;
	int cycleCount = 0;
	int waitCount;
	int mocDelay;
	int passedTests;
	int failedTests;

	controlUnit i_controlUnit (.clk(clk), .rstN(rstN), .instr(instr), .cond(cond),
		.ctrl(ctrl), .state(state));

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: no return to state 1 within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] randomBits();
		seed = lcgStep(seed);
		return seed[31:16];
	endfunction

	// One falling edge, flags random, moc raised after the picked delay
	task automatic advanceCycle();
		logic [15:0] r;
		@(negedge clk);
		r = randomBits();
		cond.zeroFlag = r[0];
		cond.branchCond = r[1];
		if (state inside {5'd3, 5'd18, 5'd23, 5'd27})
		begin
			if (waitCount == 0)
				mocDelay = r[3:2];
			cond.moc = (waitCount >= mocDelay);
			waitCount++;
		end
		else
		begin
			waitCount = 0;
			cond.moc = 1'b0;
		end
	endtask

	initial
	begin
		int startCycle;
		int errorsBefore;
		int newErrors;
		logic [15:0] r;
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		cond = '0;
		seed = 32'h46b6_b6ce;
		waitCount = 0;
		mocDelay = 0;
		passedTests = 0;
		failedTests = 0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		while (state != 5'd1)
			advanceCycle();
		for (int t = 0; t < testCount; t++)
		begin
			errorsBefore = i_controlUnit.i_controlUnitAssert.errorCount;
			startCycle = cycleCount;
			// Classes rotate, the rest of the fields are random
			r = randomBits();
			instr.op = t[1:0];
			instr.op3 = r[5:0];
			instr.immBit = r[6];
			instr.setCc = r[7];
			advanceCycle();
			while (state != 5'd1)
				advanceCycle();
			// One more edge so the jump back to state 1 is checked
			advanceCycle();
			newErrors = i_controlUnit.i_controlUnitAssert.errorCount - errorsBefore;
			if (newErrors == 0)
				passedTests++;
			else
				failedTests++;
			$display("Test %0d op %h op3 %h imm %b cc %b: %0d cycles, %s", t, instr.op,
				instr.op3, instr.immBit, instr.setCc, cycleCount - startCycle,
				(newErrors == 0) ? "ok" : "assertion errors");
		end
		$display("Tests passed %0d, failed %0d, assertion errors %0d", passedTests,
			failedTests, i_controlUnit.i_controlUnitAssert.errorCount);
		if (failedTests == 0 && i_controlUnit.i_controlUnitAssert.errorCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== project.f ====
rtl/cuPkg.sv
rtl/dispatchEncoder.sv
rtl/microSequencer.sv
rtl/microstore.sv
rtl/controlUnit.sv
test/controlUnit_assert.sv
test/controlUnitTb.sv
